// ==== source/epu_pkg.sv ====
`default_nettype none

package epu_pkg;

    localparam int MB_DIM = 16; // samples per macroblock side.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map.
    localparam logic [11:0] REG_CTRL    = 12'h000;
    localparam logic [11:0] REG_FRAME   = 12'h004;
    localparam logic [11:0] REG_RESULTS = 12'h008; // read only.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage payloads.
    typedef logic [MB_DIM-1:0][MB_DIM-1:0][7:0] mb_luma_t; // [row][col].

    typedef struct packed {
        logic [6:0] col;
        logic [6:0] row;
    } mb_pos_t;

    typedef struct packed {
        mb_pos_t  pos;
        mb_luma_t luma;
    } fetch_out_t;

    typedef struct packed {
        mb_pos_t    pos;
        mb_luma_t   luma;
        logic [7:0] dc;
    } dc_out_t;

    typedef struct packed {
        mb_pos_t     pos;
        logic [7:0]  dc;
        logic [15:0] sad;
    } mb_result_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // apb write word layouts.
    typedef struct packed {
        logic [29:0] rsvd;
        logic        soft_reset; // self clearing.
        logic        enable;
    } ctrl_reg_t;

    typedef struct packed {
        logic [3:0]  pad_hi;
        logic [11:0] height;
        logic [3:0]  pad_lo;
        logic [11:0] width;
    } frame_reg_t;

    typedef union packed {
        ctrl_reg_t  ctrl;
        frame_reg_t frame;
    } apb_word_u;

endpackage : epu_pkg

`default_nettype wire

// ==== source/epu_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module epu_apb_regs
    import epu_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire logic [11:0] paddr_i,
    input  wire apb_word_u   pwdata_i,
    output logic      [31:0] prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    input  wire logic        res_fire_i,
    output logic             enable_o,
    output logic             soft_reset_o,
    output logic      [11:0] frame_width_o,
    output logic      [11:0] frame_height_o
);

    logic        access;
    logic        known_addr;
    logic        wr_ctrl;
    logic        wr_frame;
    logic [31:0] result_cnt;
    apb_word_u   rd_word;

    assign access     = psel_i && penable_i;
    assign known_addr = (paddr_i == REG_CTRL) || (paddr_i == REG_FRAME) ||
                        (paddr_i == REG_RESULTS);
    assign wr_ctrl    = access && pwrite_i && (paddr_i == REG_CTRL);
    assign wr_frame   = access && pwrite_i && (paddr_i == REG_FRAME);

    assign pready_o  = 1'b1; // no wait states.
    assign pslverr_o = access && (!known_addr || (pwrite_i && paddr_i == REG_RESULTS));

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_o       <= 1'b0;
            soft_reset_o   <= 1'b0;
            frame_width_o  <= '0;
            frame_height_o <= '0;
        end else begin
            soft_reset_o <= wr_ctrl && pwdata_i.ctrl.soft_reset; // one cycle pulse.
            if (wr_ctrl)
                enable_o <= pwdata_i.ctrl.enable;
            if (wr_frame) begin
                frame_width_o  <= pwdata_i.frame.width;
                frame_height_o <= pwdata_i.frame.height;
            end
        end
    end

    // delivered results.
    always_ff @(posedge clk) begin
        if (rst || soft_reset_o)
            result_cnt <= '0;
        else if (res_fire_i)
            result_cnt <= result_cnt + 32'd1;
    end

    always_comb begin
        rd_word = '0;
        case (paddr_i)
            REG_CTRL:    rd_word.ctrl.enable = enable_o;
            REG_FRAME: begin
                rd_word.frame.width  = frame_width_o;
                rd_word.frame.height = frame_height_o;
            end
            REG_RESULTS: rd_word = result_cnt;
            default:     rd_word = '0;
        endcase
    end

    assign prdata_o = rd_word;

endmodule : epu_apb_regs

`default_nettype wire

// ==== source/epu_mb_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module epu_mb_fetch
    import epu_pkg::*;
#(
    parameter int MB_WORDS = 64
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        h264_reset_i,
    input  wire logic        enable_i,
    input  wire logic [11:0] frame_width_i,
    input  wire logic [11:0] frame_height_i,
    input  wire logic [31:0] data_word_i,
    input  wire logic        data_valid_i,
    output logic             fetch_req_o,
    output logic             out_valid_o,
    input  wire logic        out_ready_i,
    output fetch_out_t       out_o
);

    localparam int ROWS  = MB_WORDS / 4; // four words per row.
    localparam int ROW_W = $clog2(ROWS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_HOLD
    } state_t;

    state_t           state;
    logic [1:0]       col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic             word_fire;
    logic             last_word;
    logic             out_fire;
    logic [7:0]       mb_cols;
    logic [7:0]       mb_rows;
    logic             last_col;
    logic             frame_done;
    mb_pos_t          pos_q;
    mb_luma_t         luma_q;

    assign mb_cols    = frame_width_i[11:4];
    assign mb_rows    = frame_height_i[11:4];
    assign last_col   = ({1'b0, pos_q.col} == mb_cols - 8'd1);
    assign frame_done = ({1'b0, pos_q.row} >= mb_rows);

    assign fetch_req_o = (state == S_LOAD) && enable_i;
    assign word_fire   = fetch_req_o && data_valid_i; // other words dropped.
    assign last_word   = word_fire && (col_cnt == 2'd3) && (row_cnt == ROW_W'(ROWS - 1));
    assign out_valid_o = (state == S_HOLD);
    assign out_fire    = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (rst || h264_reset_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (enable_i && !frame_done) state <= S_LOAD;
                S_LOAD:  if (last_word) state <= S_HOLD;
                S_HOLD:  if (out_fire) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word position inside the block.
    always_ff @(posedge clk) begin
        if (rst || h264_reset_i || last_word) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (word_fire) begin
            col_cnt <= col_cnt + 2'd1;
            if (col_cnt == 2'd3)
                row_cnt <= row_cnt + ROW_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (word_fire) begin
            for (int k = 0; k < 4; k++) begin
                luma_q[row_cnt][{col_cnt, 2'(k)}] <= data_word_i[8*k +: 8]; // byte 0 leftmost.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // macroblock raster walk.
    always_ff @(posedge clk) begin
        if (rst || h264_reset_i) begin
            pos_q <= '0;
        end else if (out_fire) begin
            if (last_col) begin
                pos_q.col <= '0;
                pos_q.row <= pos_q.row + 7'd1;
            end else begin
                pos_q.col <= pos_q.col + 7'd1;
            end
        end
    end

    assign out_o = '{pos: pos_q, luma: luma_q};

endmodule : epu_mb_fetch

`default_nettype wire

// ==== source/epu_dc_pred.sv ====
`timescale 1ns/100ps
`default_nettype none

module epu_dc_pred
    import epu_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       h264_reset_i,
    input  wire logic       in_valid_i,
    output logic            in_ready_o,
    input  wire fetch_out_t in_i,
    output logic            out_valid_o,
    input  wire logic       out_ready_i,
    output dc_out_t         out_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SUM,
        S_DIV,
        S_OUT
    } state_t;

    state_t      state;
    logic [3:0]  row_cnt;
    logic [15:0] sum_q;
    logic [15:0] sum_rnd;
    logic [7:0]  dc_q;
    fetch_out_t  blk_q;

    function automatic logic [11:0] row_sum(input logic [MB_DIM-1:0][7:0] row);
        logic [11:0] acc;
        acc = '0;
        for (int i = 0; i < MB_DIM; i++) begin
            acc = acc + 12'(row[i]);
        end
        return acc;
    endfunction

    assign in_ready_o  = (state == S_IDLE);
    assign out_valid_o = (state == S_OUT);
    assign sum_rnd     = sum_q + 16'd128; // round to nearest.

    always_ff @(posedge clk) begin
        if (rst || h264_reset_i) begin
            state   <= S_IDLE;
            row_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: if (in_valid_i) begin
                    state   <= S_SUM;
                    row_cnt <= '0;
                end
                S_SUM: begin
                    row_cnt <= row_cnt + 4'd1;
                    if (row_cnt == 4'd15)
                        state <= S_DIV;
                end
                S_DIV:   state <= S_OUT;
                S_OUT:   if (out_ready_i) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            blk_q <= in_i;
            sum_q <= '0;
        end else if (state == S_SUM) begin
            sum_q <= sum_q + 16'(row_sum(blk_q.luma[row_cnt]));
        end
        if (state == S_DIV)
            dc_q <= sum_rnd[15:8]; // divide by 256.
    end

    assign out_o = '{pos: blk_q.pos, luma: blk_q.luma, dc: dc_q};

endmodule : epu_dc_pred

`default_nettype wire

// ==== source/epu_sad_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

module epu_sad_calc
    import epu_pkg::*;
#(
    parameter int MB_WORDS = 64
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    h264_reset_i,
    input  wire logic    in_valid_i,
    output logic         in_ready_o,
    input  wire dc_out_t in_i,
    output logic         out_valid_o,
    input  wire logic    out_ready_i,
    output mb_result_t   out_o
);

    localparam int ROWS  = MB_WORDS / 4;
    localparam int ROW_W = $clog2(ROWS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SUM,
        S_PACK,
        S_OUT
    } state_t;

    state_t           state;
    logic [ROW_W-1:0] row_cnt;
    logic [15:0]      total_q;
    dc_out_t          blk_q;
    mb_result_t       res_q;

    function automatic logic [11:0] row_sad(input logic [MB_DIM-1:0][7:0] row,
                                            input logic [7:0] dc);
        logic [11:0] acc;
        acc = '0;
        for (int i = 0; i < MB_DIM; i++) begin
            if (row[i] >= dc)
                acc = acc + 12'(row[i] - dc);
            else
                acc = acc + 12'(dc - row[i]);
        end
        return acc;
    endfunction

    assign in_ready_o  = (state == S_IDLE);
    assign out_valid_o = (state == S_OUT);

    always_ff @(posedge clk) begin
        if (rst || h264_reset_i) begin
            state   <= S_IDLE;
            row_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: if (in_valid_i) begin
                    state   <= S_SUM;
                    row_cnt <= '0;
                end
                S_SUM: begin
                    row_cnt <= row_cnt + ROW_W'(1);
                    if (row_cnt == ROW_W'(ROWS - 1))
                        state <= S_PACK;
                end
                S_PACK:  state <= S_OUT;
                S_OUT:   if (out_ready_i) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // one row of differences per cycle.
    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            blk_q   <= in_i;
            total_q <= '0;
        end else if (state == S_SUM) begin
            total_q <= total_q + 16'(row_sad(blk_q.luma[row_cnt], blk_q.dc));
        end
        if (state == S_PACK)
            res_q <= '{pos: blk_q.pos, dc: blk_q.dc, sad: total_q};
    end

    assign out_o = res_q; // held until accepted.

endmodule : epu_sad_calc

`default_nettype wire

// ==== source/epu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module epu_top
    import epu_pkg::*;
#(
    parameter int MB_WORDS = 64
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire logic [11:0] paddr_i,
    input  wire apb_word_u   pwdata_i,
    output logic      [31:0] prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    input  wire logic [31:0] data_word_i,
    input  wire logic        data_valid_i,
    output logic             fetch_req_o,
    output logic             res_valid_o,
    input  wire logic        res_ready_i,
    output mb_result_t       res_o
);

    logic        enable;
    logic        h264_reset;
    logic [11:0] frame_width;
    logic [11:0] frame_height;
    logic        res_fire;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_out_t  fetch_data;
    logic        dc_valid;
    logic        dc_ready;
    dc_out_t     dc_data;

    assign res_fire = res_valid_o && res_ready_i;

    epu_apb_regs u_regs (
        .clk            (clk),
        .rst            (rst),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .res_fire_i     (res_fire),
        .enable_o       (enable),
        .soft_reset_o   (h264_reset),
        .frame_width_o  (frame_width),
        .frame_height_o (frame_height)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch, dc, sad pipeline.
    epu_mb_fetch #(.MB_WORDS(MB_WORDS)) u_fetch (
        .clk            (clk),
        .rst            (rst),
        .h264_reset_i   (h264_reset),
        .enable_i       (enable),
        .frame_width_i  (frame_width),
        .frame_height_i (frame_height),
        .data_word_i    (data_word_i),
        .data_valid_i   (data_valid_i),
        .fetch_req_o    (fetch_req_o),
        .out_valid_o    (fetch_valid),
        .out_ready_i    (fetch_ready),
        .out_o          (fetch_data)
    );

    epu_dc_pred u_dc (
        .clk          (clk),
        .rst          (rst),
        .h264_reset_i (h264_reset),
        .in_valid_i   (fetch_valid),
        .in_ready_o   (fetch_ready),
        .in_i         (fetch_data),
        .out_valid_o  (dc_valid),
        .out_ready_i  (dc_ready),
        .out_o        (dc_data)
    );

    epu_sad_calc #(.MB_WORDS(MB_WORDS)) u_sad (
        .clk          (clk),
        .rst          (rst),
        .h264_reset_i (h264_reset),
        .in_valid_i   (dc_valid),
        .in_ready_o   (dc_ready),
        .in_i         (dc_data),
        .out_valid_o  (res_valid_o),
        .out_ready_i  (res_ready_i),
        .out_o        (res_o)
    );

endmodule : epu_top

`default_nettype wire

// ==== tb/epu_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module epu_assertions
    import epu_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       h264_reset_i,
    input wire logic       fetch_req_i,
    input wire logic       fetch_valid_i,
    input wire logic       fetch_ready_i,
    input wire fetch_out_t fetch_data_i,
    input wire logic       dc_valid_i,
    input wire logic       dc_ready_i,
    input wire dc_out_t    dc_data_i,
    input wire logic       res_valid_i,
    input wire logic       res_ready_i,
    input wire mb_result_t res_i
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshakes hold until ready unless soft reset hits.
    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        (fetch_valid_i && !fetch_ready_i && !h264_reset_i) |=> fetch_valid_i)
        else $error("fetch valid dropped before ready");

    a_fetch_stable: assert property (@(posedge clk) disable iff (rst)
        (fetch_valid_i && !fetch_ready_i && !h264_reset_i) |=> $stable(fetch_data_i))
        else $error("fetch payload changed while stalled");

    a_dc_hold: assert property (@(posedge clk) disable iff (rst)
        (dc_valid_i && !dc_ready_i && !h264_reset_i) |=> dc_valid_i)
        else $error("dc valid dropped before ready");

    a_dc_stable: assert property (@(posedge clk) disable iff (rst)
        (dc_valid_i && !dc_ready_i && !h264_reset_i) |=> $stable(dc_data_i))
        else $error("dc payload changed while stalled");

    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        (res_valid_i && !res_ready_i && !h264_reset_i) |=> res_valid_i)
        else $error("result valid dropped before ready");

    a_res_stable: assert property (@(posedge clk) disable iff (rst)
        (res_valid_i && !res_ready_i && !h264_reset_i) |=> $stable(res_i))
        else $error("result payload changed while stalled");

    a_req_after_reset: assert property (@(posedge clk)
        (rst || h264_reset_i) |=> !fetch_req_i)
        else $error("fetch request high right after reset");

endmodule : epu_assertions

bind epu_top epu_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .h264_reset_i  (h264_reset),
    .fetch_req_i   (fetch_req_o),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_i (fetch_ready),
    .fetch_data_i  (fetch_data),
    .dc_valid_i    (dc_valid),
    .dc_ready_i    (dc_ready),
    .dc_data_i     (dc_data),
    .res_valid_i   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_i         (res_o)
);

`default_nettype wire

// ==== tb/epu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module epu_checker
    import epu_pkg::*;
#(
    parameter int NUM_MB = 6
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire logic [11:0] paddr_i,
    input  wire logic [31:0] pwdata_i,
    input  wire logic [31:0] prdata_i,
    input  wire logic        pready_i,
    input  wire logic        pslverr_i,
    input  wire logic        res_valid_i,
    input  wire logic        res_ready_i,
    input  wire mb_result_t  res_i,
    input  wire logic [31:0] vec_i [0:5*NUM_MB],
    output int               err_cnt_o,
    output int               chk_cnt_o,
    output int               res_cnt_o
);

    logic        enable_q;
    logic [31:0] frame_q;
    logic        clr_pending; // count clears one cycle after the write.

    task automatic compare(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
        chk_cnt_o++;
        if (act !== exp) begin
            err_cnt_o++;
            $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register model.
    task automatic check_apb();
        logic [31:0] exp_rd;
        logic        exp_err;
        exp_err = !(paddr_i inside {REG_CTRL, REG_FRAME, REG_RESULTS}) ||
                  (pwrite_i && paddr_i == REG_RESULTS);
        compare("pslverr_o", {31'd0, exp_err}, {31'd0, pslverr_i});
        compare("pready_o", 32'd1, {31'd0, pready_i}); // no wait states.
        if (pwrite_i) begin
            if (paddr_i == REG_CTRL) begin
                enable_q <= pwdata_i[0];
                if (pwdata_i[1])
                    clr_pending <= 1'b1;
            end else if (paddr_i == REG_FRAME) begin
                frame_q <= {4'd0, pwdata_i[27:16], 4'd0, pwdata_i[11:0]};
            end
        end else begin
            case (paddr_i)
                REG_CTRL:    exp_rd = {31'd0, enable_q};
                REG_FRAME:   exp_rd = frame_q;
                REG_RESULTS: exp_rd = 32'(res_cnt_o);
                default:     exp_rd = '0;
            endcase
            compare("prdata_o", exp_rd, prdata_i);
        end
    endtask

    task automatic check_result(input int idx);
        int cols;
        cols = int'(vec_i[0][11:4]);
        if (idx >= NUM_MB) begin
            err_cnt_o++;
            $display("result %0d arrived after the last macroblock of the frame at %0t",
                     idx, $time);
        end else begin
            compare("res_o.pos.col", 32'(idx % cols), 32'(res_i.pos.col)); // raster order.
            compare("res_o.pos.row", 32'(idx / cols), 32'(res_i.pos.row));
            compare("res_o.dc", vec_i[4 + 5*idx], 32'(res_i.dc));
            compare("res_o.sad", vec_i[5 + 5*idx], 32'(res_i.sad));
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            err_cnt_o = 0;
            chk_cnt_o = 0;
            res_cnt_o   <= 0;
            enable_q    <= 1'b0;
            frame_q     <= '0;
            clr_pending <= 1'b0;
        end else begin
            if (psel_i && penable_i)
                check_apb();
            if (clr_pending) begin
                res_cnt_o   <= 0; // a result taken here is dropped.
                clr_pending <= 1'b0;
            end else if (res_valid_i && res_ready_i) begin
                check_result(res_cnt_o);
                res_cnt_o <= res_cnt_o + 1;
            end
        end
    end

endmodule : epu_checker

`default_nettype wire

// ==== tb/epu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module epu_tb
    import epu_pkg::*;
();

    localparam int MB_WORDS        = 64;
    localparam int NUM_MB          = 6;
    localparam int VEC_WORDS       = 1 + 5 * NUM_MB;
    localparam int WATCHDOG_CYCLES = 2 * NUM_MB * (MB_WORDS + 40) * 4 + 1000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] data_word  = '0;
    logic        data_valid = 1'b0;
    logic        res_ready  = 1'b0;
    logic        fetch_req;
    logic        res_valid;
    mb_result_t  res;
    logic        restart    = 1'b0;

    logic [31:0] vec [0:VEC_WORDS-1];
    integer      seed = 32'h6a28_145d;
    int          word_idx;
    int          mb_idx;
    int          err_cnt;
    int          chk_cnt;
    int          res_cnt;
    int          tests_run;
    int          test_err_base;

    epu_top #(.MB_WORDS(MB_WORDS)) UUT (
        .clk          (clk),
        .rst          (rst),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .data_word_i  (data_word),
        .data_valid_i (data_valid),
        .fetch_req_o  (fetch_req),
        .res_valid_o  (res_valid),
        .res_ready_i  (res_ready),
        .res_o        (res)
    );

    epu_checker #(.NUM_MB(NUM_MB)) u_checker (
        .clk         (clk),
        .rst         (rst),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_i    (prdata),
        .pready_i    (pready),
        .pslverr_i   (pslverr),
        .res_valid_i (res_valid),
        .res_ready_i (res_ready),
        .res_i       (res),
        .vec_i       (vec),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt),
        .res_cnt_o   (res_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one 32-bit word of the pattern with byte 0 leftmost.
    function automatic logic [31:0] pixel_word(input int mb, input int w);
        logic [31:0] word;
        logic [7:0]  base;
        logic [7:0]  cstep;
        logic [7:0]  rstep;
        int          row;
        int          col;
        int          k;
        word = '0;
        if (mb < NUM_MB) begin
            base  = vec[1 + 5*mb][7:0];
            cstep = vec[2 + 5*mb][7:0];
            rstep = vec[3 + 5*mb][7:0];
            row   = w / 4;
            for (k = 0; k < 4; k++) begin
                col = (w % 4) * 4 + k;
                word[8*k +: 8] = 8'(base + col * cstep + row * rstep); // modulo 256.
            end
        end
        return word;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel stream and result stalls.
    always @(posedge clk) begin
        if (rst || restart) begin
            word_idx = 0;
            mb_idx   = 0;
            data_valid <= 1'b0;
            res_ready  <= 1'b0;
        end else begin
            if (fetch_req && data_valid) begin // word taken at this edge.
                if (word_idx == MB_WORDS - 1) begin
                    word_idx = 0;
                    mb_idx   = mb_idx + 1;
                end else begin
                    word_idx = word_idx + 1;
                end
            end
            data_valid <= (($random(seed) & 32'h3) != 32'h0);
            res_ready  <= (($random(seed) & 32'h1) != 32'h0);
            data_word  <= pixel_word(mb_idx, word_idx);
        end
    end

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk); // access phase without wait states.
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr);
        apb_access(1'b0, addr, 32'h0);
    endtask

    task automatic wait_results(input int n);
        while (res_cnt < n)
            @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        tests_run++;
        if (err_cnt == test_err_base)
            $display("test %0d %s: passed", tests_run, name);
        else
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence.
    initial begin
        $readmemh("tb/epu_vectors.txt", vec);
        tests_run     = 0;
        test_err_base = 0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        apb_read(REG_FRAME);
        apb_read(REG_RESULTS);
        apb_read(REG_CTRL);
        apb_read(12'h00c); // unmapped.
        apb_access(1'b1, REG_RESULTS, 32'h5);
        apb_read(REG_RESULTS);
        finish_test("reset values and decode");

        apb_access(1'b1, REG_FRAME, vec[0]);
        apb_access(1'b1, REG_CTRL, 32'h1);
        wait_results(3);
        apb_access(1'b1, REG_CTRL, 32'h3); // soft reset with enable kept.
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        apb_read(REG_RESULTS);
        finish_test("partial frame and soft reset");

        wait_results(NUM_MB);
        repeat (4 * (MB_WORDS + 40)) @(posedge clk); // nothing past the last row.
        apb_read(REG_RESULTS);
        apb_read(REG_FRAME);
        apb_read(REG_CTRL);
        finish_test("full frame rerun");

        $display("summary: %0d tests, %0d checks, %0d results, %0d errors",
                 tests_run, chk_cnt, res_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule : epu_tb

`default_nettype wire

// ==== tb/epu_vectors.txt ====
// word 0: frame size, height in bits 27:16, width in bits 11:0
// then per macroblock: base col_step row_step expected_dc expected_sad
00200030
10 00 00 10 0000
00 01 00 08 0400
20 00 02 2f 0800
f0 01 01 87 7a30
80 ff 00 79 0400
ff 00 00 ff 0000

// ==== verilog.f ====
source/epu_pkg.sv
source/epu_apb_regs.sv
source/epu_mb_fetch.sv
source/epu_dc_pred.sv
source/epu_sad_calc.sv
source/epu_top.sv
tb/epu_assertions.sv
tb/epu_checker.sv
tb/epu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= epu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
